// ==== include/rv_core_defs.svh ====
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// Datapath width
`define XLEN 32

// Register file geometry
`define REG_ADDR_W 5
`define NUM_REGS 32

// First fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

// ==== hw/rv_core_pkg.sv ====
package rv_core_pkg;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_COPY2   // passes operand 2, used by LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        OP1_RS1,
        OP1_PC,
        OP1_ZERO
    } op1_sel_e;

    typedef enum logic [1:0] {
        OP2_RS2,
        OP2_IMM_I,
        OP2_IMM_U
    } op2_sel_e;

    // Next PC source
    typedef enum logic [1:0] {
        PC_PLUS4,
        PC_BRANCH,
        PC_JAL,
        PC_JALR
    } pc_sel_e;

    // Register write-back source
    typedef enum logic {
        WB_ALU,
        WB_PC4
    } wb_sel_e;

endpackage

// ==== hw/ctrl_if.sv ====
`timescale 1ns/10ps

interface ctrl_if
    import rv_core_pkg::*;
();

    alu_op_e  alu_op;
    op1_sel_e op1_sel;
    op2_sel_e op2_sel;
    pc_sel_e  pc_sel;
    logic     rf_we;
    wb_sel_e  wb_sel;

    // Driven by the decoder only
    modport producer (output alu_op, op1_sel, op2_sel, pc_sel, rf_we, wb_sel);

    modport ifu_mp (input pc_sel);
    modport idu_mp (input op1_sel, op2_sel);
    modport exu_mp (input alu_op, wb_sel);
    modport rf_mp  (input rf_we);

endinterface

// ==== hw/reg_file.sv ====
`timescale 1ns/10ps
`include "rv_core_defs.svh"

module reg_file (
    input  logic                   clk,
    ctrl_if.rf_mp                  ctrl,
    input  logic [`REG_ADDR_W-1:0] raddr1_i,
    input  logic [`REG_ADDR_W-1:0] raddr2_i,
    input  logic [`REG_ADDR_W-1:0] waddr_i,
    input  logic [`XLEN-1:0]       wdata_i,
    output logic [`XLEN-1:0]       rdata1_o,
    output logic [`XLEN-1:0]       rdata2_o
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (ctrl.rf_we) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Reads of x0 return zero
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

    // Decoder must never let a write reach x0
    a_no_x0_write: assert property (
        @(posedge clk) ctrl.rf_we |-> (waddr_i != '0)
    ) else $error("register write to x0");

endmodule

// ==== hw/ifu.sv ====
`timescale 1ns/10ps
`include "rv_core_defs.svh"

module ifu
    import rv_core_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n_i,
    ctrl_if.ifu_mp           ctrl,
    input  logic [`XLEN-1:0] br_target_i,
    input  logic [`XLEN-1:0] jmp_target_i,
    input  logic [`XLEN-1:0] jalr_target_i,
    output logic [`XLEN-1:0] pc_o
);

    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] pc_next;

    // Next PC selection
    always_comb begin
        case (ctrl.pc_sel)
            PC_BRANCH: pc_next = br_target_i;
            PC_JAL:    pc_next = jmp_target_i;
            PC_JALR:   pc_next = jalr_target_i;
            default:   pc_next = pc_q + `XLEN'(4);
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= `RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

    // Targets from the IDU must keep the PC on a word boundary
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n_i) pc_q[1:0] == 2'b00
    ) else $error("misaligned PC %h", pc_q);

endmodule

// ==== hw/idu.sv ====
`timescale 1ns/10ps
`include "rv_core_defs.svh"

module idu
    import rv_core_pkg::*;
(
    input  logic [31:0]            inst_i,
    input  logic [`XLEN-1:0]       pc_i,
    ctrl_if.idu_mp                 ctrl,
    input  logic [`XLEN-1:0]       rs1_data_i,
    input  logic [`XLEN-1:0]       rs2_data_i,
    output logic [`REG_ADDR_W-1:0] rs1_addr_o,
    output logic [`REG_ADDR_W-1:0] rs2_addr_o,
    output logic [`REG_ADDR_W-1:0] rd_addr_o,
    output logic [`XLEN-1:0]       op1_o,
    output logic [`XLEN-1:0]       op2_o,
    output logic [`XLEN-1:0]       br_target_o,
    output logic [`XLEN-1:0]       jmp_target_o,
    output logic [`XLEN-1:0]       jalr_target_o,
    output logic [`XLEN-1:0]       pc_plus4_o,
    output logic                   br_eq_o,
    output logic                   br_lt_o,
    output logic                   br_ltu_o
);

    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] jalr_sum;

    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_addr_o  = inst_i[11:7];

    // Sign-extended immediates
    assign imm_i = {{(`XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_b = {{(`XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7],
                    inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{(`XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12],
                    inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};

    always_comb begin
        case (ctrl.op1_sel)
            OP1_PC:   op1_o = pc_i;
            OP1_ZERO: op1_o = '0;
            default:  op1_o = rs1_data_i;
        endcase
    end

    always_comb begin
        case (ctrl.op2_sel)
            OP2_IMM_I: op2_o = imm_i;
            OP2_IMM_U: op2_o = imm_u;
            default:   op2_o = rs2_data_i;
        endcase
    end

    assign pc_plus4_o   = pc_i + `XLEN'(4);
    assign br_target_o  = pc_i + imm_b;
    assign jmp_target_o = pc_i + imm_j;

    // JALR drops bit 0 of the sum
    assign jalr_sum      = rs1_data_i + imm_i;
    assign jalr_target_o = {jalr_sum[`XLEN-1:1], 1'b0};

    assign br_eq_o  = (rs1_data_i == rs2_data_i);
    assign br_lt_o  = ($signed(rs1_data_i) < $signed(rs2_data_i));
    assign br_ltu_o = (rs1_data_i < rs2_data_i);

endmodule

// ==== hw/control_logic.sv ====
`timescale 1ns/10ps

module control_logic
    import rv_core_pkg::*;
(
    input  logic [31:0] inst_i,
    input  logic        rst_n_i,
    input  logic        br_eq_i,
    input  logic        br_lt_i,
    input  logic        br_ltu_i,
    ctrl_if.producer    ctrl
);

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [4:0]  rd;
    logic        legal;
    logic        writes_rd;
    logic        br_taken;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd     = inst_i[11:7];

    // Map funct3 to an ALU op with alt picking SUB or SRA
    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // Branch condition per funct3
    // Encodings 010 and 011 are reserved
    always_comb begin
        case (funct3)
            3'b000:  br_taken = br_eq_i;
            3'b001:  br_taken = !br_eq_i;
            3'b100:  br_taken = br_lt_i;
            3'b101:  br_taken = !br_lt_i;
            3'b110:  br_taken = br_ltu_i;
            3'b111:  br_taken = !br_ltu_i;
            default: br_taken = 1'b0;
        endcase
    end

    always_comb begin
        // No-op defaults
        ctrl.alu_op  = ALU_ADD;
        ctrl.op1_sel = OP1_ZERO;
        ctrl.op2_sel = OP2_RS2;
        ctrl.pc_sel  = PC_PLUS4;
        ctrl.wb_sel  = WB_ALU;
        legal        = 1'b0;
        writes_rd    = 1'b0;
        case (opcode)
            OPC_OP: begin
                legal = (funct7 == F7_BASE) ||
                        (funct7 == F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101));
                writes_rd    = 1'b1;
                ctrl.op1_sel = OP1_RS1;
                ctrl.alu_op  = alu_from_funct(funct3, funct7[5]);
            end
            OPC_OP_IMM: begin
                // Shift immediates carry funct7 in the top bits
                if (funct3 == 3'b001) begin
                    legal = (funct7 == F7_BASE);
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                end else begin
                    legal = 1'b1;
                end
                writes_rd    = 1'b1;
                ctrl.op1_sel = OP1_RS1;
                ctrl.op2_sel = OP2_IMM_I;
                ctrl.alu_op  = alu_from_funct(funct3, (funct3 == 3'b101) && funct7[5]);
            end
            OPC_LUI: begin
                legal        = 1'b1;
                writes_rd    = 1'b1;
                ctrl.op2_sel = OP2_IMM_U;
                ctrl.alu_op  = ALU_COPY2;
            end
            OPC_AUIPC: begin
                legal        = 1'b1;
                writes_rd    = 1'b1;
                ctrl.op1_sel = OP1_PC;
                ctrl.op2_sel = OP2_IMM_U;
            end
            OPC_JAL: begin
                legal       = 1'b1;
                writes_rd   = 1'b1;
                ctrl.pc_sel = PC_JAL;
                ctrl.wb_sel = WB_PC4;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    legal       = 1'b1;
                    writes_rd   = 1'b1;
                    ctrl.pc_sel = PC_JALR;
                    ctrl.wb_sel = WB_PC4;
                end
            end
            OPC_BRANCH: begin
                legal       = (funct3 != 3'b010) && (funct3 != 3'b011);
                ctrl.pc_sel = br_taken ? PC_BRANCH : PC_PLUS4;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // Commit only real writes, never to x0 and never in reset
    assign ctrl.rf_we = rst_n_i && legal && writes_rd && (rd != 5'd0);

endmodule

// ==== hw/exu.sv ====
`timescale 1ns/10ps
`include "rv_core_defs.svh"

module exu
    import rv_core_pkg::*;
(
    ctrl_if.exu_mp           ctrl,
    input  logic [`XLEN-1:0] op1_i,
    input  logic [`XLEN-1:0] op2_i,
    input  logic [`XLEN-1:0] pc_plus4_i,
    output logic [`XLEN-1:0] wdata_o
);

    logic [`XLEN-1:0]         alu_res;
    logic [$clog2(`XLEN)-1:0] shamt;

    // Shift amount from the low bits of operand 2
    assign shamt = op2_i[$clog2(`XLEN)-1:0];

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:   alu_res = op1_i + op2_i;
            ALU_SUB:   alu_res = op1_i - op2_i;
            ALU_SLL:   alu_res = op1_i << shamt;
            ALU_SLT:   alu_res = {{(`XLEN-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
            ALU_SLTU:  alu_res = {{(`XLEN-1){1'b0}}, op1_i < op2_i};
            ALU_XOR:   alu_res = op1_i ^ op2_i;
            ALU_SRL:   alu_res = op1_i >> shamt;
            ALU_SRA:   alu_res = $signed(op1_i) >>> shamt;
            ALU_OR:    alu_res = op1_i | op2_i;
            ALU_AND:   alu_res = op1_i & op2_i;
            ALU_COPY2: alu_res = op2_i;
            default:   alu_res = '0;
        endcase
    end

    // Link value for jumps, ALU result otherwise
    assign wdata_o = (ctrl.wb_sel == WB_PC4) ? pc_plus4_i : alu_res;

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/10ps
`include "rv_core_defs.svh"

module rv_core (
    input  logic                   clk,
    input  logic                   rst_n_i,
    // Instruction memory, answers combinationally
    output logic [`XLEN-1:0]       imem_addr_o,
    input  logic [31:0]            imem_rdata_i,
    // Commit port for debug
    output logic [`XLEN-1:0]       pc_o,
    output logic                   rf_we_o,
    output logic [`REG_ADDR_W-1:0] rf_waddr_o,
    output logic [`XLEN-1:0]       rf_wdata_o
);

    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       op1;
    logic [`XLEN-1:0]       op2;
    logic [`XLEN-1:0]       pc_plus4;
    logic [`XLEN-1:0]       br_target;
    logic [`XLEN-1:0]       jmp_target;
    logic [`XLEN-1:0]       jalr_target;
    logic [`XLEN-1:0]       rdata1;
    logic [`XLEN-1:0]       rdata2;
    logic [`XLEN-1:0]       wdata;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`REG_ADDR_W-1:0] rd_addr;
    logic                   br_eq;
    logic                   br_lt;
    logic                   br_ltu;

    ctrl_if ctrl_bus ();

    reg_file u_reg_file (
        .clk      (clk),
        .ctrl     (ctrl_bus.rf_mp),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .waddr_i  (rd_addr),
        .wdata_i  (wdata),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    ifu u_ifu (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .ctrl          (ctrl_bus.ifu_mp),
        .br_target_i   (br_target),
        .jmp_target_i  (jmp_target),
        .jalr_target_i (jalr_target),
        .pc_o          (pc)
    );

    idu u_idu (
        .inst_i        (imem_rdata_i),
        .pc_i          (pc),
        .ctrl          (ctrl_bus.idu_mp),
        .rs1_data_i    (rdata1),
        .rs2_data_i    (rdata2),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rd_addr_o     (rd_addr),
        .op1_o         (op1),
        .op2_o         (op2),
        .br_target_o   (br_target),
        .jmp_target_o  (jmp_target),
        .jalr_target_o (jalr_target),
        .pc_plus4_o    (pc_plus4),
        .br_eq_o       (br_eq),
        .br_lt_o       (br_lt),
        .br_ltu_o      (br_ltu)
    );

    control_logic u_control_logic (
        .inst_i   (imem_rdata_i),
        .rst_n_i  (rst_n_i),
        .br_eq_i  (br_eq),
        .br_lt_i  (br_lt),
        .br_ltu_i (br_ltu),
        .ctrl     (ctrl_bus.producer)
    );

    exu u_exu (
        .ctrl       (ctrl_bus.exu_mp),
        .op1_i      (op1),
        .op2_i      (op2),
        .pc_plus4_i (pc_plus4),
        .wdata_o    (wdata)
    );

    assign imem_addr_o = pc;
    assign pc_o        = pc;

    // Register write port seen from outside
    assign rf_we_o    = ctrl_bus.rf_we;
    assign rf_waddr_o = rd_addr;
    assign rf_wdata_o = wdata;

endmodule

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Release just after an edge, like every other driven input
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

// ==== tb/tb_rv_core.sv ====
`timescale 1ns/10ps
`include "rv_core_defs.svh"

module tb_rv_core
    import rv_core_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 3;
    localparam int MARGIN       = 20;
    localparam logic [31:0] SEED = 32'h2f34a31e;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] pc;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;

    // Program ROM and per-step expectations from the shadow model
    logic [31:0] rom [0:255];
    logic [31:0] exp_pc [0:255];
    logic        exp_we [0:255];
    logic [4:0]  exp_waddr [0:255];
    logic [31:0] exp_wdata [0:255];
    logic [31:0] sreg [0:31];
    logic [31:0] bpc;
    logic [31:0] rng;
    int          n_steps;
    int          step;
    int          errors;
    logic        built;

    logic        checking;
    logic [31:0] cur_pc;
    logic        cur_we;
    logic [4:0]  cur_waddr;
    logic [31:0] cur_wdata;

    tb_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    rv_core u_dut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .pc_o         (pc),
        .rf_we_o      (rf_we),
        .rf_waddr_o   (rf_waddr),
        .rf_wdata_o   (rf_wdata)
    );

    // ROM answers the fetch address in the same cycle, in reset too
    assign imem_rdata = rom[imem_addr[9:2]];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step <= 0;
        end else begin
            step <= step + 1;
        end
    end

    assign checking  = rst_n && (step < n_steps);
    assign cur_pc    = exp_pc[step[7:0]];
    assign cur_we    = exp_we[step[7:0]];
    assign cur_waddr = exp_waddr[step[7:0]];
    assign cur_wdata = exp_wdata[step[7:0]];

    a_reset_we: assert property (@(posedge clk) !rst_n |-> !rf_we)
        else begin
            errors++;
            $display("rf_we_o was high while reset was asserted");
        end

    a_reset_pc: assert property (@(posedge clk) $rose(rst_n) |-> pc == `RESET_PC)
        else begin
            errors++;
            $display("error pc_o after reset: got %h expected %h", $sampled(pc), `RESET_PC);
        end

    a_pc: assert property (@(posedge clk) checking |-> pc == cur_pc)
        else begin
            errors++;
            $display("error pc_o: got %h expected %h at step %0d",
                     $sampled(pc), $sampled(cur_pc), $sampled(step));
        end

    a_imem_addr: assert property (@(posedge clk) checking |-> imem_addr == cur_pc)
        else begin
            errors++;
            $display("error imem_addr_o: got %h expected %h at step %0d",
                     $sampled(imem_addr), $sampled(cur_pc), $sampled(step));
        end

    a_we: assert property (@(posedge clk) checking |-> rf_we == cur_we)
        else begin
            errors++;
            $display("error rf_we_o: got %h expected %h at step %0d",
                     $sampled(rf_we), $sampled(cur_we), $sampled(step));
        end

    a_waddr: assert property (@(posedge clk) checking && cur_we |-> rf_waddr == cur_waddr)
        else begin
            errors++;
            $display("error rf_waddr_o: got %h expected %h at step %0d",
                     $sampled(rf_waddr), $sampled(cur_waddr), $sampled(step));
        end

    a_wdata: assert property (@(posedge clk) checking && cur_we |-> rf_wdata == cur_wdata)
        else begin
            errors++;
            $display("error rf_wdata_o: got %h expected %h at step %0d",
                     $sampled(rf_wdata), $sampled(cur_wdata), $sampled(step));
        end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Source registers x1..x8 hold the random operands
    function automatic int rand_reg();
        logic [31:0] w;
        w = rand_word();
        return 1 + int'(w[2:0]);
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input int rs1, input int f3,
                                          input int rd, input logic [6:0] opc);
        return {imm, rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input int rs2, input int rs1,
                                          input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
    endfunction

    // Signed less-than from the sign bits
    function automatic logic slt_ref(input logic [31:0] a, input logic [31:0] b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic logic [31:0] alu_ref(input int f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] r;
        sh = b[4:0];
        case (f3)
            0: r = alt ? a - b : a + b;
            1: r = a << sh;
            2: r = {31'b0, slt_ref(a, b)};
            3: r = {31'b0, a < b};
            4: r = a ^ b;
            5: begin
                r = a >> sh;
                // Fill vacated upper bits with the sign
                if (alt && a[31]) begin
                    r = r | ~(32'hffff_ffff >> sh);
                end
            end
            6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic br_ref(input int f3, input logic [31:0] a, input logic [31:0] b);
        logic t;
        case (f3)
            0: t = (a == b);
            1: t = (a != b);
            4: t = slt_ref(a, b);
            5: t = !slt_ref(a, b);
            6: t = (a < b);
            default: t = (a >= b);
        endcase
        return t;
    endfunction

    // Place one instruction and record what the core must show for it
    task automatic emit(input logic [31:0] inst, input int rd, input logic writes,
                        input logic [31:0] wdata, input logic [31:0] next_pc);
        rom[bpc[9:2]] = inst;
        exp_pc[n_steps[7:0]]    = bpc;
        exp_we[n_steps[7:0]]    = writes && (rd != 0);
        exp_waddr[n_steps[7:0]] = rd[4:0];
        exp_wdata[n_steps[7:0]] = wdata;
        if (writes && (rd != 0)) begin
            sreg[rd[4:0]] = wdata;
        end
        bpc = next_pc;
        n_steps++;
    endtask

    task automatic op_reg(input int f3, input logic alt, input int rd, input int rs1,
                          input int rs2);
        logic [31:0] res;
        res = alu_ref(f3, alt, sreg[rs1[4:0]], sreg[rs2[4:0]]);
        emit(enc_r(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd), rd, 1'b1, res, bpc + 4);
    endtask

    task automatic op_imm(input int f3, input int rd, input int rs1, input logic [11:0] imm);
        logic        alt;
        logic [31:0] res;
        alt = (f3 == 5) && imm[10];
        res = alu_ref(f3, alt, sreg[rs1[4:0]], {{20{imm[11]}}, imm});
        emit(enc_i(imm, rs1, f3, rd, OPC_OP_IMM), rd, 1'b1, res, bpc + 4);
    endtask

    task automatic lui(input int rd, input logic [19:0] imm);
        emit({imm, rd[4:0], OPC_LUI}, rd, 1'b1, {imm, 12'b0}, bpc + 4);
    endtask

    task automatic auipc(input int rd, input logic [19:0] imm);
        emit({imm, rd[4:0], OPC_AUIPC}, rd, 1'b1, bpc + {imm, 12'b0}, bpc + 4);
    endtask

    // LUI of the rounded upper part, then ADDI of the low twelve bits
    task automatic load_reg(input int rd, input logic [31:0] v);
        logic [31:0] upper;
        upper = v + 32'h0000_0800;
        lui(rd, upper[31:12]);
        op_imm(0, rd, rd, v[11:0]);
    endtask

    // Taken branches skip one word
    task automatic branch(input int f3, input int rs1, input int rs2);
        logic taken;
        taken = br_ref(f3, sreg[rs1[4:0]], sreg[rs2[4:0]]);
        emit(enc_b(13'd8, rs2, rs1, f3), 0, 1'b0, 32'h0, taken ? bpc + 8 : bpc + 4);
    endtask

    task automatic jalr(input int rd, input int rs1, input logic [11:0] imm);
        logic [31:0] tgt;
        tgt = sreg[rs1[4:0]] + {{20{imm[11]}}, imm};
        tgt[0] = 1'b0;
        emit(enc_i(imm, rs1, 0, rd, OPC_JALR), rd, 1'b1, bpc + 4, tgt);
    endtask

    task automatic build_program();
        int          i;
        logic [31:0] w;
        int          br_kinds [6] = '{0, 1, 4, 5, 6, 7};
        int          imm_kinds [6] = '{0, 2, 3, 4, 6, 7};
        int          pair_a [3] = '{1, 28, 29};
        int          pair_b [3] = '{9, 29, 28};
        for (i = 1; i <= 8; i++) begin
            load_reg(i, rand_word());
        end
        load_reg(9, sreg[1]);
        load_reg(28, 32'd5);
        load_reg(29, 32'hffff_fffd);

        for (i = 0; i < 8; i++) begin
            op_reg(i, 1'b0, 10 + i, rand_reg(), rand_reg());
        end
        op_reg(0, 1'b1, 18, rand_reg(), rand_reg());
        op_reg(5, 1'b1, 19, rand_reg(), rand_reg());

        for (i = 0; i < 6; i++) begin
            w = rand_word();
            op_imm(imm_kinds[i], 10 + i, rand_reg(), w[11:0]);
        end
        w = rand_word();
        op_imm(1, 20, rand_reg(), {7'h00, w[4:0]});
        op_imm(5, 21, rand_reg(), {7'h00, w[9:5]});
        op_imm(5, 22, rand_reg(), {7'h20, w[14:10]});

        w = rand_word();
        lui(23, w[31:12]);
        auipc(24, w[19:0]);

        // Equal, signed-greater and signed-less pairs cover both outcomes
        for (i = 0; i < 18; i++) begin
            branch(br_kinds[i % 6], pair_a[i / 6], pair_b[i / 6]);
        end

        emit(enc_j(21'd8, 30), 30, 1'b1, bpc + 4, bpc + 8);
        auipc(24, 20'h0);
        jalr(25, 24, 12'd13);

        // No-op cases
        op_imm(0, 0, 1, 12'h07b);
        emit(32'hffff_ffff, 0, 1'b0, 32'h0, bpc + 4);
        emit(enc_r(7'h01, 2, 1, 0, 26), 26, 1'b0, 32'h0, bpc + 4);
        op_reg(0, 1'b0, 26, 0, 0);
        op_reg(6, 1'b0, 27, 0, 1);
    endtask

    initial begin
        errors  = 0;
        n_steps = 0;
        built   = 1'b0;
        rng     = SEED;
        bpc     = `RESET_PC;
        for (int a = 0; a < 256; a++) begin
            // Opcode zero is illegal
            // Upper bits carry the word address
            rom[a]       = {a[24:0], 7'b0000000};
            exp_pc[a]    = 32'h0;
            exp_we[a]    = 1'b0;
            exp_waddr[a] = 5'h0;
            exp_wdata[a] = 32'h0;
        end
        for (int r = 0; r < 32; r++) begin
            sreg[r] = 32'h0;
        end
        build_program();
        built = 1'b1;

        wait (rst_n);
        wait (step == n_steps);
        @(posedge clk);
        #1;
        $display("errors: %0d, steps: %0d", errors, n_steps);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog sized from the program length
    initial begin
        wait (built);
        #((n_steps + RESET_CYCLES + MARGIN) * CLK_PERIOD);
        errors++;
        $display("Timeout: the core did not finish the program in %0d cycles",
                 n_steps + RESET_CYCLES + MARGIN);
        $display("errors: %0d, steps: %0d", errors, step);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
hw/rv_core_pkg.sv
hw/ctrl_if.sv
hw/reg_file.sv
hw/ifu.sv
hw/idu.sv
hw/control_logic.sv
hw/exu.sv
hw/rv_core.sv
tb/tb_clk_gen.sv
tb/tb_rv_core.sv

// ==== Makefile ====
# Verilator flow for the RV32I core

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
